//--- Bender.yml
package:
  name: trap_unit

sources:
  - core_pipe_pkg.sv
  - trap_csr_pkg.sv
  - exc_prio.sv
  - irq_arbiter.sv
  - trap_csr.sv
  - trap_ctrl.sv
  - trap_top.sv
  - target: test
    files:
      - trap_asserts.sv
      - tb_trap.sv

//--- core_pipe_pkg.sv
// Pipeline types shared between the writeback stage and the trap unit.
// Holds the retiring instruction as seen at writeback and the source
// select used when the trap unit redirects the fetch PC.
// Compile this package before any file that refers to it.

package core_pipe_pkg;

  // Instruction address, fixed at RV32
  typedef logic [31:0] pc_t;

  // One instruction at the writeback boundary together with its flags
  // The flags are only meaningful while valid is set
  typedef struct packed {
    logic valid;
    pc_t  pc;
    // Instruction fetch was refused by the MPU
    logic mpu_err;
    // Instruction fetch returned a bus error
    logic bus_err;
    logic illegal;
    logic ecall;
    logic ebreak;
    logic mret;
  } wb_instr_t;

  // Where the redirected fetch PC comes from
  typedef enum logic [0:0] {
    PC_TRAP = 1'b0,
    PC_MRET = 1'b1
  } pc_mux_e;

endpackage

//--- exc_prio.sv
// Exception priority encoder for the writeback instruction.
// Reduces the fault flags of a valid instruction to one cause code in the
// fixed order MPU fault, bus fault, illegal, ECALL, EBREAK. Purely
// combinational; MRET is not looked at here.

module exc_prio (
  input  core_pipe_pkg::wb_instr_t wb_instr_i,
  output logic                     exc_valid_o,
  output trap_csr_pkg::exc_code_t  exc_code_o
);

  import trap_csr_pkg::*;

  always_comb begin
    exc_valid_o = 1'b0;
    exc_code_o  = '0;
    // Nothing is raised for a bubble, whatever its flags say
    if (wb_instr_i.valid) begin
      // Fetch faults come first since the instruction bits are not trustworthy
      if (wb_instr_i.mpu_err) begin
        exc_valid_o = 1'b1;
        exc_code_o  = EXC_INSTR_FAULT;
      end else if (wb_instr_i.bus_err) begin
        exc_valid_o = 1'b1;
        exc_code_o  = EXC_INSTR_BUS_FAULT;
      end else if (wb_instr_i.illegal) begin
        exc_valid_o = 1'b1;
        exc_code_o  = EXC_ILLEGAL;
      end else if (wb_instr_i.ecall) begin
        exc_valid_o = 1'b1;
        exc_code_o  = EXC_ECALL_M;
      end else if (wb_instr_i.ebreak) begin
        exc_valid_o = 1'b1;
        exc_code_o  = EXC_BREAKPOINT;
      end
    end
  end

endmodule

//--- irq_arbiter.sv
// Interrupt selection for the trap unit.
// Masks the request levels with mie and the global enable, then reports
// the lowest-numbered remaining line. Purely combinational.

module irq_arbiter (
  input  trap_csr_pkg::irq_vec_t  irq_i,
  input  trap_csr_pkg::csr_data_t mie_i,
  input  logic                    mstatus_mie_i,
  output logic                    irq_valid_o,
  output trap_csr_pkg::exc_code_t irq_id_o
);

  import trap_csr_pkg::*;

  irq_vec_t irq_pending;

  // A line counts only when its own enable and the global enable are set
  assign irq_pending = irq_i & mie_i & {32{mstatus_mie_i}};

  assign irq_valid_o = |irq_pending;

  // Scan from the top down so the lowest set index is written last and wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 31; i >= 0; i--) begin
      if (irq_pending[i]) begin
        irq_id_o = exc_code_t'(i);
      end
    end
  end

endmodule

//--- tb.f
core_pipe_pkg.sv
trap_csr_pkg.sv
exc_prio.sv
irq_arbiter.sv
trap_csr.sv
trap_ctrl.sv
trap_top.sv
trap_asserts.sv
tb_trap.sv

//--- tb_trap.sv
// Testbench for the machine-mode trap unit.
// Reads one line of stimulus per cycle from trap_patterns.txt, drives the
// DUT one time unit after the rising edge and checks the registered
// outputs one cycle later. Errors are counted and summed up at the end.

module tb_trap;

  import core_pipe_pkg::*;
  import trap_csr_pkg::*;

  localparam int unsigned RESET_CYCLES  = 16;
  localparam int unsigned RESET_TIMEOUT = 64;
  localparam int unsigned MAX_LINES     = 1000;

  // What the outputs should show one cycle after a line is applied
  typedef struct packed {
    logic      pc_set;
    logic      pc_mux;
    pc_t       pc_target;
    logic      irq_ack;
    exc_code_t irq_id;
    logic      retire;
    logic      check_rdata;
    csr_data_t rdata;
  } expect_t;

  logic        clk;
  logic        rst_ni;
  wb_instr_t   wb_instr;
  irq_vec_t    irq;
  logic        csr_we;
  csr_addr_t   csr_addr;
  csr_data_t   csr_wdata;
  csr_data_t   csr_rdata;
  logic        pc_set;
  pc_mux_e     pc_mux;
  pc_t         pc_target;
  logic        irq_ack;
  exc_code_t   irq_id;
  logic        retire;

  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned n_patterns;
  bit          aborted;

  trap_top i_trap_top (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .wb_instr_i  (wb_instr),
    .irq_i       (irq),
    .csr_we_i    (csr_we),
    .csr_addr_i  (csr_addr),
    .csr_wdata_i (csr_wdata),
    .csr_rdata_o (csr_rdata),
    .pc_set_o    (pc_set),
    .pc_mux_o    (pc_mux),
    .pc_target_o (pc_target),
    .irq_ack_o   (irq_ack),
    .irq_id_o    (irq_id),
    .retire_o    (retire)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_ni = 1'b1;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_value(input string test, input string field,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    n_checks++;
    assert (act_v === exp_v) else begin
      n_errors++;
      $display("ERROR %s %s: expected %h, actual %h", test, field, exp_v, act_v);
    end
  endtask

  task automatic check_outputs(input string test, input expect_t e);
    check_value(test, "pc_set", 32'(e.pc_set), 32'(pc_set));
    check_value(test, "pc_mux", 32'(e.pc_mux), 32'(pc_mux));
    check_value(test, "pc_target", e.pc_target, pc_target);
    check_value(test, "irq_ack", 32'(e.irq_ack), 32'(irq_ack));
    check_value(test, "irq_id", 32'(e.irq_id), 32'(irq_id));
    check_value(test, "retire", 32'(e.retire), 32'(retire));
    // The read port is combinational, so the address is still applied here
    if (e.check_rdata) begin
      check_value(test, "csr_rdata", e.rdata, csr_rdata);
    end
  endtask

  // Q, R and N only set the irq level and the CSR address
  task automatic apply_stimulus(input string cmd, input logic [31:0] pc,
                                input logic [31:0] flags, input logic [31:0] irq_lvl,
                                input logic [31:0] addr, input logic [31:0] wdata);
    wb_instr  = '0;
    csr_we    = 1'b0;
    irq       = irq_lvl;
    csr_addr  = addr[11:0];
    csr_wdata = wdata;
    if (cmd == "I") begin
      wb_instr.valid = 1'b1;
      wb_instr.pc    = pc;
      {wb_instr.mpu_err, wb_instr.bus_err, wb_instr.illegal,
       wb_instr.ecall, wb_instr.ebreak, wb_instr.mret} = flags[5:0];
    end else if (cmd == "W") begin
      csr_we = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int          fd;
    int          n_fields;
    int unsigned n_lines;
    int unsigned wait_cycles;
    int unsigned n_assert_fail;
    string       line;
    string       name;
    string       cmd;
    logic [31:0] col [0:11];
    expect_t     exp_out;

    wb_instr   = '0;
    irq        = '0;
    csr_we     = 1'b0;
    csr_addr   = '0;
    csr_wdata  = '0;
    n_checks   = 0;
    n_errors   = 0;
    n_patterns = 0;
    aborted    = 1'b0;

    wait_cycles = 0;
    while (rst_ni !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      wait_cycles++;
    end

    if (rst_ni !== 1'b1) begin
      $display("Timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
      aborted = 1'b1;
    end else begin
      fd = $fopen("trap_patterns.txt", "r");
      if (fd == 0) begin
        $display("Could not open the pattern file trap_patterns.txt");
        aborted = 1'b1;
      end else begin
        @(posedge clk);
        #1;
        n_lines = 0;
        while (!$feof(fd) && n_lines < MAX_LINES) begin
          n_lines++;
          line = "";
          // Comment lines start with # and blank lines hold only a newline
          if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
            n_fields = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h",
                               name, cmd, col[0], col[1], col[2], col[3], col[4],
                               col[5], col[6], col[7], col[8], col[9], col[10], col[11]);
            if (n_fields == 14) begin
              apply_stimulus(cmd, col[0], col[1], col[2], col[3], col[4]);
              exp_out = '{pc_set: col[5][0], pc_mux: col[6][0], pc_target: col[7],
                          irq_ack: col[8][0], irq_id: col[9][4:0], retire: col[10][0],
                          check_rdata: (cmd == "R"), rdata: col[11]};
              @(posedge clk);
              #1;
              check_outputs(name, exp_out);
              n_patterns++;
            end else begin
              $display("Pattern line %0d could not be parsed", n_lines);
              aborted = 1'b1;
            end
          end
        end
        if (!$feof(fd)) begin
          $display("Timeout: pattern file not finished after %0d lines", MAX_LINES);
          aborted = 1'b1;
        end
        $fclose(fd);
        if (n_patterns == 0) begin
          $display("No patterns were applied");
          aborted = 1'b1;
        end
      end
    end

    // Property failures of the bound checker count against the run as well
    n_assert_fail = i_trap_top.i_trap_asserts.n_fail;
    $display("Patterns: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             n_patterns, n_checks, n_errors, n_assert_fail);
    if (aborted || n_errors != 0 || n_assert_fail != 0) begin
      $display("Checks failed");
    end else begin
      $display("All checks passed");
    end
    $finish;
  end

endmodule

//--- trap_asserts.sv
// Concurrent checks on the trap unit, bound into trap_top.
// Watches the trap request between controller and CSRs, the saved CSR
// state and the redirect pulse. Reports only through failing assertions
// and keeps a count of them.

module trap_asserts (
  input logic                    clk,
  input logic                    rst_ni,
  input trap_csr_pkg::irq_vec_t  irq_i,
  input trap_csr_pkg::csr_data_t mie_i,
  input logic                    mstatus_mie_i,
  input trap_csr_pkg::trap_req_t trap_req_i,
  input core_pipe_pkg::pc_t      mepc_i,
  input trap_csr_pkg::mcause_t   mcause_i,
  input logic                    pc_set_i
);

  logic irq_taken;

  // Number of property failures seen so far
  int unsigned n_fail = 0;

  // An interrupt commits when the request carries the irq flag
  assign irq_taken = trap_req_i.valid && trap_req_i.cause.irq;

  ////////////////////////////////////////
  // Interrupt entry
  ////////////////////////////////////////

  // The line must have been requested, enabled in mie and globally enabled
  irq_was_enabled: assert property (@(posedge clk) disable iff (!rst_ni)
    irq_taken |-> mstatus_mie_i && mie_i[trap_req_i.cause.code] &&
                  irq_i[trap_req_i.cause.code])
    else begin
      $error("Interrupt %0d taken while masked", trap_req_i.cause.code);
      n_fail++;
    end

  // One cycle later the cause is saved and further interrupts are off
  irq_saved: assert property (@(posedge clk) disable iff (!rst_ni)
    irq_taken |=> mcause_i.irq && (mcause_i.code == $past(trap_req_i.cause.code)) &&
                  !mstatus_mie_i)
    else begin
      $error("mcause or MIE wrong after an interrupt");
      n_fail++;
    end

  ////////////////////////////////////////
  // Trap state and redirect
  ////////////////////////////////////////

  // mepc holds the PC of the instruction that trapped
  epc_saved: assert property (@(posedge clk) disable iff (!rst_ni)
    trap_req_i.valid |=> mepc_i == $past(trap_req_i.epc))
    else begin
      $error("mepc does not match the trapping PC");
      n_fail++;
    end

  // The FLUSH cycle keeps redirects at least two cycles apart
  no_back_to_back_redirect: assert property (@(posedge clk) disable iff (!rst_ni)
    pc_set_i |=> !pc_set_i)
    else begin
      $error("pc_set asserted in two consecutive cycles");
      n_fail++;
    end

endmodule

bind trap_top trap_asserts i_trap_asserts (
  .clk           (clk),
  .rst_ni        (rst_ni),
  .irq_i         (irq_i),
  .mie_i         (mie),
  .mstatus_mie_i (mstatus_mie),
  .trap_req_i    (trap_req),
  .mepc_i        (mepc),
  .mcause_i      (i_trap_csr.mcause_q),
  .pc_set_i      (pc_set_o)
);

//--- trap_csr.sv
// Machine-mode trap CSRs.
// Holds mstatus (MIE and MPIE), mie, mtvec, mepc and mcause. Serves the
// CSR write strobe and a combinational read port, saves the trap state
// when the controller commits a trap and restores MIE on MRET. A trap or
// MRET in the same cycle as a CSR write wins for the fields it updates.

module trap_csr (
  input  logic                    clk,
  input  logic                    rst_ni,
  input  logic                    csr_we_i,
  input  trap_csr_pkg::csr_addr_t csr_addr_i,
  input  trap_csr_pkg::csr_data_t csr_wdata_i,
  output trap_csr_pkg::csr_data_t csr_rdata_o,
  input  trap_csr_pkg::trap_req_t trap_req_i,
  input  logic                    mret_i,
  output trap_csr_pkg::csr_data_t mie_o,
  output logic                    mstatus_mie_o,
  output trap_csr_pkg::mtvec_t    mtvec_o,
  output core_pipe_pkg::pc_t      mepc_o
);

  import core_pipe_pkg::*;
  import trap_csr_pkg::*;

  logic      mstatus_mie_q;
  logic      mstatus_mie_d;
  logic      mstatus_mpie_q;
  logic      mstatus_mpie_d;
  csr_data_t mie_q;
  csr_data_t mie_d;
  mtvec_t    mtvec_q;
  mtvec_t    mtvec_d;
  pc_t       mepc_q;
  pc_t       mepc_d;
  mcause_t   mcause_q;
  mcause_t   mcause_d;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    mstatus_mie_d  = mstatus_mie_q;
    mstatus_mpie_d = mstatus_mpie_q;
    mie_d          = mie_q;
    mtvec_d        = mtvec_q;
    mepc_d         = mepc_q;
    mcause_d       = mcause_q;

    // Software writes, masked to the bits that exist
    if (csr_we_i) begin
      case (csr_addr_i)
        CSR_MSTATUS: begin
          mstatus_mie_d  = csr_wdata_i[MSTATUS_MIE_BIT];
          mstatus_mpie_d = csr_wdata_i[MSTATUS_MPIE_BIT];
        end
        CSR_MIE:    mie_d = csr_wdata_i;
        // Only direct and vectored modes are supported
        CSR_MTVEC:  mtvec_d = '{base: csr_wdata_i[31:2], mode: {1'b0, csr_wdata_i[0]}};
        CSR_MEPC:   mepc_d = {csr_wdata_i[31:2], 2'b00};
        CSR_MCAUSE: mcause_d = '{irq: csr_wdata_i[31], code: csr_wdata_i[4:0]};
        default: ;
      endcase
    end

    // Hardware updates override the write for the fields they touch
    if (trap_req_i.valid) begin
      mepc_d         = trap_req_i.epc;
      mcause_d       = trap_req_i.cause;
      mstatus_mpie_d = mstatus_mie_q;
      mstatus_mie_d  = 1'b0;
    end else if (mret_i) begin
      mstatus_mie_d  = mstatus_mpie_q;
      mstatus_mpie_d = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mie_q          <= '0;
      mtvec_q        <= '0;
      mepc_q         <= '0;
      mcause_q       <= '0;
    end else begin
      mstatus_mie_q  <= mstatus_mie_d;
      mstatus_mpie_q <= mstatus_mpie_d;
      mie_q          <= mie_d;
      mtvec_q        <= mtvec_d;
      mepc_q         <= mepc_d;
      mcause_q       <= mcause_d;
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      CSR_MSTATUS: begin
        csr_rdata_o[MSTATUS_MIE_BIT]  = mstatus_mie_q;
        csr_rdata_o[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
      end
      CSR_MIE:    csr_rdata_o = mie_q;
      CSR_MTVEC:  csr_rdata_o = mtvec_q;
      CSR_MEPC:   csr_rdata_o = mepc_q;
      // The interrupt flag lives in bit 31 and the code in the low bits
      CSR_MCAUSE: csr_rdata_o = {mcause_q.irq, 26'b0, mcause_q.code};
      default:    csr_rdata_o = '0;
    endcase
  end

  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;
  assign mtvec_o       = mtvec_q;
  assign mepc_o        = mepc_q;

endmodule

//--- trap_csr_pkg.sv
// Machine-mode trap definitions for the trap unit.
// Contains the CSR address map, the exception cause codes, the layouts
// of mcause and mtvec, and the request passed from the controller to the
// CSR block when a trap is committed. Depends on core_pipe_pkg.

package trap_csr_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // One request line per bit of mie
  typedef logic [31:0] irq_vec_t;

  // Cause code, also wide enough to hold an interrupt index
  typedef logic [4:0] exc_code_t;

  ////////////////////////////////////////
  // Cause codes
  ////////////////////////////////////////

  localparam exc_code_t EXC_INSTR_FAULT     = 5'd1;
  localparam exc_code_t EXC_ILLEGAL         = 5'd2;
  localparam exc_code_t EXC_BREAKPOINT      = 5'd3;
  localparam exc_code_t EXC_ECALL_M         = 5'd11;
  localparam exc_code_t EXC_INSTR_BUS_FAULT = 5'd24;

  ////////////////////////////////////////
  // CSR map
  ////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  // Implemented mstatus bits
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  // mtvec mode value that selects per-interrupt entry points
  localparam logic [1:0] MTVEC_VECTORED = 2'd1;

  // Stored part of mcause; bit 31 of the CSR maps to irq
  typedef struct packed {
    logic      irq;
    exc_code_t code;
  } mcause_t;

  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;
  } mtvec_t;

  // Trap being committed this cycle
  typedef struct packed {
    logic               valid;
    mcause_t            cause;
    core_pipe_pkg::pc_t epc;
  } trap_req_t;

  typedef enum logic [0:0] {
    IDLE  = 1'b0,
    FLUSH = 1'b1
  } trap_state_e;

endpackage

//--- trap_ctrl.sv
// Trap controller.
// Decides in IDLE what the valid writeback instruction does: interrupt,
// exception, MRET or plain retire. The trap request and MRET strobe go to
// the CSRs in the same cycle; the redirect, ack and retire pulses are
// registered and last one cycle. After a redirect one FLUSH cycle follows
// in which the writeback instruction is dropped.

module trap_ctrl (
  input  logic                     clk,
  input  logic                     rst_ni,
  input  core_pipe_pkg::wb_instr_t wb_instr_i,
  input  logic                     exc_valid_i,
  input  trap_csr_pkg::exc_code_t  exc_code_i,
  input  logic                     irq_valid_i,
  input  trap_csr_pkg::exc_code_t  irq_id_i,
  input  trap_csr_pkg::mtvec_t     mtvec_i,
  input  core_pipe_pkg::pc_t       mepc_i,
  output trap_csr_pkg::trap_req_t  trap_req_o,
  output logic                     mret_o,
  output logic                     pc_set_o,
  output core_pipe_pkg::pc_mux_e   pc_mux_o,
  output core_pipe_pkg::pc_t       pc_target_o,
  output logic                     irq_ack_o,
  output trap_csr_pkg::exc_code_t  irq_id_o,
  output logic                     retire_o
);

  import core_pipe_pkg::*;
  import trap_csr_pkg::*;

  trap_state_e state_q;
  trap_state_e state_d;
  logic        pc_set_d;
  pc_mux_e     pc_mux_d;
  pc_t         pc_target_d;
  logic        irq_ack_d;
  exc_code_t   irq_id_d;
  logic        retire_d;
  pc_t         trap_base;
  pc_t         irq_offset;

  // Handler entry points; vectored mode spreads interrupts 4 bytes apart
  assign trap_base  = {mtvec_i.base, 2'b00};
  assign irq_offset = (mtvec_i.mode == MTVEC_VECTORED) ? {25'b0, irq_id_i, 2'b00} : '0;

  always_comb begin
    state_d     = state_q;
    trap_req_o  = '0;
    mret_o      = 1'b0;
    pc_set_d    = 1'b0;
    pc_mux_d    = PC_TRAP;
    pc_target_d = '0;
    irq_ack_d   = 1'b0;
    irq_id_d    = '0;
    retire_d    = 1'b0;

    case (state_q)
      IDLE: begin
        if (wb_instr_i.valid) begin
          if (irq_valid_i) begin
            // The interrupt displaces the instruction, so epc is its PC
            trap_req_o  = '{valid: 1'b1, cause: '{irq: 1'b1, code: irq_id_i},
                            epc: wb_instr_i.pc};
            pc_set_d    = 1'b1;
            pc_target_d = trap_base + irq_offset;
            irq_ack_d   = 1'b1;
            irq_id_d    = irq_id_i;
            state_d     = FLUSH;
          end else if (exc_valid_i) begin
            trap_req_o  = '{valid: 1'b1, cause: '{irq: 1'b0, code: exc_code_i},
                            epc: wb_instr_i.pc};
            pc_set_d    = 1'b1;
            pc_target_d = trap_base;
            state_d     = FLUSH;
          end else if (wb_instr_i.mret) begin
            mret_o      = 1'b1;
            pc_set_d    = 1'b1;
            pc_mux_d    = PC_MRET;
            pc_target_d = mepc_i;
            state_d     = FLUSH;
          end else begin
            retire_d = 1'b1;
          end
        end
      end
      // Whatever sits in writeback now was fetched down the old path
      FLUSH:   state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      pc_set_o    <= 1'b0;
      pc_mux_o    <= PC_TRAP;
      pc_target_o <= '0;
      irq_ack_o   <= 1'b0;
      irq_id_o    <= '0;
      retire_o    <= 1'b0;
    end else begin
      state_q     <= state_d;
      pc_set_o    <= pc_set_d;
      pc_mux_o    <= pc_mux_d;
      pc_target_o <= pc_target_d;
      irq_ack_o   <= irq_ack_d;
      irq_id_o    <= irq_id_d;
      retire_o    <= retire_d;
    end
  end

endmodule

//--- trap_patterns.txt
# name cmd pc flags irq csr_addr csr_wdata, then expected pc_set pc_mux pc_target irq_ack irq_id retire rdata
# cmd I instr, Q irq level, W CSR write, R CSR read-check, N idle; flags bits mpu bus ill ecall ebreak mret
rd_mstatus0   R 00000000 00 00000000 300 00000000 0 0 00000000 0 00 0 00000000
retire_plain  I 00000100 00 00000000 000 00000000 0 0 00000000 0 00 1 00000000
wr_mtvec      W 00000000 00 00000000 305 00000200 0 0 00000000 0 00 0 00000000
exc_mpu_ill   I 00000104 28 00000000 000 00000000 1 0 00000200 0 00 0 00000000
flush_drop1   I 00000108 00 00000000 000 00000000 0 0 00000000 0 00 0 00000000
rd_mcause1    R 00000000 00 00000000 342 00000000 0 0 00000000 0 00 0 00000001
rd_mepc1      R 00000000 00 00000000 341 00000000 0 0 00000000 0 00 0 00000104
exc_bus_ecall I 00000110 14 00000000 000 00000000 1 0 00000200 0 00 0 00000000
flush_idle2   N 00000000 00 00000000 000 00000000 0 0 00000000 0 00 0 00000000
rd_mcause2    R 00000000 00 00000000 342 00000000 0 0 00000000 0 00 0 00000018
exc_ecall_brk I 00000120 06 00000000 000 00000000 1 0 00000200 0 00 0 00000000
flush_drop3   I 00000124 00 00000000 000 00000000 0 0 00000000 0 00 0 00000000
rd_mcause3    R 00000000 00 00000000 342 00000000 0 0 00000000 0 00 0 0000000b
rd_mepc3      R 00000000 00 00000000 341 00000000 0 0 00000000 0 00 0 00000120
irq_raise     Q 00000000 00 00000031 000 00000000 0 0 00000000 0 00 0 00000000
irq_no_mie    I 00000130 00 00000031 000 00000000 0 0 00000000 0 00 1 00000000
wr_mie        W 00000000 00 00000031 304 00000030 0 0 00000000 0 00 0 00000000
irq_no_gie    I 00000134 00 00000031 000 00000000 0 0 00000000 0 00 1 00000000
wr_mstatus    W 00000000 00 00000031 300 00000008 0 0 00000000 0 00 0 00000000
irq_take      I 00000140 08 00000031 000 00000000 1 0 00000200 1 04 0 00000000
flush_drop4   I 00000144 00 00000031 000 00000000 0 0 00000000 0 00 0 00000000
rd_mcause4    R 00000000 00 00000031 342 00000000 0 0 00000000 0 00 0 80000004
rd_mstatus4   R 00000000 00 00000031 300 00000000 0 0 00000000 0 00 0 00000080
rd_mepc4      R 00000000 00 00000000 341 00000000 0 0 00000000 0 00 0 00000140
mret_return   I 00000150 01 00000000 000 00000000 1 1 00000140 0 00 0 00000000
flush_drop5   I 00000154 00 00000000 000 00000000 0 0 00000000 0 00 0 00000000
rd_mstatus5   R 00000000 00 00000000 300 00000000 0 0 00000000 0 00 0 00000088
wr_mtvec_vec  W 00000000 00 00000000 305 00000201 0 0 00000000 0 00 0 00000000
irq_vectored  I 00000160 00 00000020 000 00000000 1 0 00000214 1 05 0 00000000
flush_idle6   N 00000000 00 00000000 000 00000000 0 0 00000000 0 00 0 00000000
exc_vectored  I 00000170 02 00000000 000 00000000 1 0 00000200 0 00 0 00000000
flush_idle7   N 00000000 00 00000000 000 00000000 0 0 00000000 0 00 0 00000000
rd_mcause7    R 00000000 00 00000000 342 00000000 0 0 00000000 0 00 0 00000003
retire_end    I 00000180 00 00000000 000 00000000 0 0 00000000 0 00 1 00000000
idle_end      N 00000000 00 00000000 000 00000000 0 0 00000000 0 00 0 00000000

//--- trap_top.sv
// Top level of the machine-mode trap unit.
// Wires the exception priority encoder, the interrupt arbiter, the trap
// CSRs and the trap controller together. It is placed at the writeback
// boundary of the core and redirects fetch through pc_set_o.

module trap_top (
  input  logic                     clk,
  input  logic                     rst_ni,
  input  core_pipe_pkg::wb_instr_t wb_instr_i,
  input  trap_csr_pkg::irq_vec_t   irq_i,
  input  logic                     csr_we_i,
  input  trap_csr_pkg::csr_addr_t  csr_addr_i,
  input  trap_csr_pkg::csr_data_t  csr_wdata_i,
  output trap_csr_pkg::csr_data_t  csr_rdata_o,
  output logic                     pc_set_o,
  output core_pipe_pkg::pc_mux_e   pc_mux_o,
  output core_pipe_pkg::pc_t       pc_target_o,
  output logic                     irq_ack_o,
  output trap_csr_pkg::exc_code_t  irq_id_o,
  output logic                     retire_o
);

  import core_pipe_pkg::*;
  import trap_csr_pkg::*;

  logic      exc_valid;
  exc_code_t exc_code;
  logic      irq_valid;
  exc_code_t irq_id;
  csr_data_t mie;
  logic      mstatus_mie;
  mtvec_t    mtvec;
  pc_t       mepc;
  trap_req_t trap_req;
  logic      mret;

  exc_prio i_exc_prio (
    .wb_instr_i  (wb_instr_i),
    .exc_valid_o (exc_valid),
    .exc_code_o  (exc_code)
  );

  irq_arbiter i_irq_arbiter (
    .irq_i         (irq_i),
    .mie_i         (mie),
    .mstatus_mie_i (mstatus_mie),
    .irq_valid_o   (irq_valid),
    .irq_id_o      (irq_id)
  );

  trap_csr i_trap_csr (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .csr_we_i      (csr_we_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_rdata_o   (csr_rdata_o),
    .trap_req_i    (trap_req),
    .mret_i        (mret),
    .mie_o         (mie),
    .mstatus_mie_o (mstatus_mie),
    .mtvec_o       (mtvec),
    .mepc_o        (mepc)
  );

  trap_ctrl i_trap_ctrl (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .wb_instr_i  (wb_instr_i),
    .exc_valid_i (exc_valid),
    .exc_code_i  (exc_code),
    .irq_valid_i (irq_valid),
    .irq_id_i    (irq_id),
    .mtvec_i     (mtvec),
    .mepc_i      (mepc),
    .trap_req_o  (trap_req),
    .mret_o      (mret),
    .pc_set_o    (pc_set_o),
    .pc_mux_o    (pc_mux_o),
    .pc_target_o (pc_target_o),
    .irq_ack_o   (irq_ack_o),
    .irq_id_o    (irq_id_o),
    .retire_o    (retire_o)
  );

endmodule
